// File: verilog/pamFilterPkg.sv
package pamFilterPkg;

	// word width shared by the input, every pipeline word and y
	localparam int SAMPLE_WIDTH = 18;

	// 15 symmetric taps fold into 7 pairs plus one center tap
	localparam int TAP_COUNT = 15;
	localparam int PAIR_COUNT = (TAP_COUNT - 1) / 2;
	localparam int PRODUCT_COUNT = PAIR_COUNT + 1;
	localparam int CENTER_TAP = PAIR_COUNT;

	// one level unit once the input is halved to 2s16
	// PAM symbols +-1 and +-3 land on +-1 and +-3 units
	localparam int LEVEL_STEP = 16384;

	// half-width of the match window around a level
	localparam int TOLERANCE = 10;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	// central taps of the long pulse shaping filter, scaled by 1/4
	// index 0 is the outer pair, index 7 the center tap
	// 6 * sum(|coef|) = 46992, well under 2^17
	localparam sample_t UNIT_COEF [PRODUCT_COUNT] = '{
		-18'sd188,
		-18'sd443,
		-18'sd462,
		-18'sd106,
		18'sd601,
		18'sd1456,
		18'sd2154,
		18'sd2422
	};

	// classified level of a pre-sum
	// even multiples are legal pair sums, odd ones are legal center samples
	typedef enum logic [3:0] {
		LVL_NEG6 = 4'd0,
		LVL_NEG4 = 4'd1,
		LVL_NEG2 = 4'd2,
		LVL_ZERO = 4'd3,
		LVL_POS2 = 4'd4,
		LVL_POS4 = 4'd5,
		LVL_POS6 = 4'd6,
		LVL_NEG3 = 4'd8,
		LVL_NEG1 = 4'd9,
		LVL_POS1 = 4'd10,
		LVL_POS3 = 4'd11,
		LVL_NONE = 4'd15
	} levelCode_t;

	// output of the pre-adder stage
	typedef struct packed {
		sample_t [PAIR_COUNT-1:0] pairSum;
		sample_t centerSample;
	} preSumBus_t;

	// output of the table product stage
	// product[CENTER_TAP] belongs to the center tap
	typedef struct packed {
		sample_t [PRODUCT_COUNT-1:0] product;
	} productBus_t;

endpackage

// File: verilog/foldedDelayLine.sv
`timescale 1ns/10ps

// input scaling, 15-sample shift register and symmetric pre-adder
// the pre-sums registered at enable n+1 come from the taps after enable n
module foldedDelayLine (
	input logic sys_clk,
	input logic reset,
	input logic sampleEn,
	input pamFilterPkg::sample_t x_in,
	output pamFilterPkg::preSumBus_t preSum
);

	pamFilterPkg::sample_t taps [pamFilterPkg::TAP_COUNT];
	pamFilterPkg::sample_t halvedSample;

	// 1s17 to 2s16, sign bit repeated
	// keeps a pair sum of two +-3 symbols inside 18 bits
	assign halvedSample = x_in >>> 1;

	// sample delay line, moves only on the sample enable
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < pamFilterPkg::TAP_COUNT; i++) begin
				taps[i] <= '0;
			end
		end else if (sampleEn) begin
			taps[0] <= halvedSample;
			for (int i = 1; i < pamFilterPkg::TAP_COUNT; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// fold the symmetric pairs
	// tap k and tap 14-k share one coefficient, so one product per pair
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			preSum <= '0;
		end else if (sampleEn) begin
			for (int k = 0; k < pamFilterPkg::PAIR_COUNT; k++) begin
				preSum.pairSum[k] <= taps[k] + taps[pamFilterPkg::TAP_COUNT-1-k];
			end
			// odd length, the middle tap has no partner
			preSum.centerSample <= taps[pamFilterPkg::CENTER_TAP];
		end
	end

endmodule

// File: verilog/levelLutMultiplier.sv
`timescale 1ns/10ps

// multiplier-free product stage
// each pre-sum can only sit on a few levels, so the product is a table value
module levelLutMultiplier (
	input logic sys_clk,
	input logic reset,
	input logic sampleEn,
	input pamFilterPkg::preSumBus_t preSum,
	output pamFilterPkg::productBus_t products
);

	pamFilterPkg::levelCode_t pairLevel [pamFilterPkg::PAIR_COUNT];
	pamFilterPkg::levelCode_t centerLevel;

	// true when value is strictly inside the window around multiple * step
	function automatic logic nearLevel(input pamFilterPkg::sample_t value, input int multiple);
		int distance;
		distance = int'(value) - multiple * pamFilterPkg::LEVEL_STEP;
		return (distance > -pamFilterPkg::TOLERANCE) && (distance < pamFilterPkg::TOLERANCE);
	endfunction

	// sum of two halved symbols: 0, +-2, +-4, +-6 units
	function automatic pamFilterPkg::levelCode_t classifyPair(input pamFilterPkg::sample_t value);
		pamFilterPkg::levelCode_t code;
		if (nearLevel(value, -6)) code = pamFilterPkg::LVL_NEG6;
		else if (nearLevel(value, -4)) code = pamFilterPkg::LVL_NEG4;
		else if (nearLevel(value, -2)) code = pamFilterPkg::LVL_NEG2;
		else if (nearLevel(value, 0)) code = pamFilterPkg::LVL_ZERO;
		else if (nearLevel(value, 2)) code = pamFilterPkg::LVL_POS2;
		else if (nearLevel(value, 4)) code = pamFilterPkg::LVL_POS4;
		else if (nearLevel(value, 6)) code = pamFilterPkg::LVL_POS6;
		else code = pamFilterPkg::LVL_NONE;
		return code;
	endfunction

	// single halved symbol on the center tap: +-1, +-3 units
	function automatic pamFilterPkg::levelCode_t classifyCenter(input pamFilterPkg::sample_t value);
		pamFilterPkg::levelCode_t code;
		if (nearLevel(value, -3)) code = pamFilterPkg::LVL_NEG3;
		else if (nearLevel(value, -1)) code = pamFilterPkg::LVL_NEG1;
		else if (nearLevel(value, 1)) code = pamFilterPkg::LVL_POS1;
		else if (nearLevel(value, 3)) code = pamFilterPkg::LVL_POS3;
		else code = pamFilterPkg::LVL_NONE;
		return code;
	endfunction

	// signed level multiple, no match gives a zero product
	function automatic int levelMultiple(input pamFilterPkg::levelCode_t code);
		int multiple;
		case (code)
			pamFilterPkg::LVL_NEG6: multiple = -6;
			pamFilterPkg::LVL_NEG4: multiple = -4;
			pamFilterPkg::LVL_NEG3: multiple = -3;
			pamFilterPkg::LVL_NEG2: multiple = -2;
			pamFilterPkg::LVL_NEG1: multiple = -1;
			pamFilterPkg::LVL_POS1: multiple = 1;
			pamFilterPkg::LVL_POS2: multiple = 2;
			pamFilterPkg::LVL_POS3: multiple = 3;
			pamFilterPkg::LVL_POS4: multiple = 4;
			pamFilterPkg::LVL_POS6: multiple = 6;
			default: multiple = 0;
		endcase
		return multiple;
	endfunction

	// table entry, coefficient times level multiple
	function automatic pamFilterPkg::sample_t tableProduct(input int index,
			input pamFilterPkg::levelCode_t code);
		return pamFilterPkg::sample_t'(int'(pamFilterPkg::UNIT_COEF[index]) * levelMultiple(code));
	endfunction

	always_comb begin
		for (int k = 0; k < pamFilterPkg::PAIR_COUNT; k++) begin
			pairLevel[k] = classifyPair(preSum.pairSum[k]);
		end
		centerLevel = classifyCenter(preSum.centerSample);
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			products <= '0;
		end else if (sampleEn) begin
			for (int k = 0; k < pamFilterPkg::PAIR_COUNT; k++) begin
				products.product[k] <= tableProduct(k, pairLevel[k]);
			end
			products.product[pamFilterPkg::CENTER_TAP] <=
				tableProduct(pamFilterPkg::CENTER_TAP, centerLevel);
		end
	end

endmodule

// File: verilog/productAdderTree.sv
`timescale 1ns/10ps

// registered adder tree, 8 products to 4 to 2 to y
// three enables from products to y
module productAdderTree (
	input logic sys_clk,
	input logic reset,
	input logic sampleEn,
	input pamFilterPkg::productBus_t products,
	output pamFilterPkg::sample_t y
);

	// partial sums per level
	pamFilterPkg::sample_t levelOneSum [pamFilterPkg::PRODUCT_COUNT/2];
	pamFilterPkg::sample_t levelTwoSum [pamFilterPkg::PRODUCT_COUNT/4];

	// level 1, neighbouring products
	// coefficient bound keeps every partial sum inside 18 bits
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < pamFilterPkg::PRODUCT_COUNT/2; i++) begin
				levelOneSum[i] <= '0;
			end
		end else if (sampleEn) begin
			for (int i = 0; i < pamFilterPkg::PRODUCT_COUNT/2; i++) begin
				levelOneSum[i] <= products.product[2*i] + products.product[2*i+1];
			end
		end
	end

	// level 2
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < pamFilterPkg::PRODUCT_COUNT/4; i++) begin
				levelTwoSum[i] <= '0;
			end
		end else if (sampleEn) begin
			for (int i = 0; i < pamFilterPkg::PRODUCT_COUNT/4; i++) begin
				levelTwoSum[i] <= levelOneSum[2*i] + levelOneSum[2*i+1];
			end
		end
	end

	// level 3, filter output
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			y <= '0;
		end else if (sampleEn) begin
			y <= levelTwoSum[0] + levelTwoSum[1];
		end
	end

endmodule

// File: verilog/pamShapingFilter.sv
`timescale 1ns/10ps

// folded symmetric FIR for a 4-level PAM stream
// sample in at enable n shows up on y after enable n+5
module pamShapingFilter (
	input logic sys_clk,
	input logic reset,
	input logic sampleEn,
	input pamFilterPkg::sample_t x_in,
	output pamFilterPkg::sample_t y
);

	// stage buses
	pamFilterPkg::preSumBus_t preSum;
	pamFilterPkg::productBus_t products;

	// halve, delay and fold the taps
	foldedDelayLine delayLine (
		.sys_clk (sys_clk),
		.reset (reset),
		.sampleEn (sampleEn),
		.x_in (x_in),
		.preSum (preSum)
	);

	// level match and coefficient table lookup
	levelLutMultiplier lutMultiplier (
		.sys_clk (sys_clk),
		.reset (reset),
		.sampleEn (sampleEn),
		.preSum (preSum),
		.products (products)
	);

	// three registered sum levels down to y
	productAdderTree adderTree (
		.sys_clk (sys_clk),
		.reset (reset),
		.sampleEn (sampleEn),
		.products (products),
		.y (y)
	);

endmodule

// File: bench/pamShapingFilter_sva.sv
`timescale 1ns/10ps

// output checks on the filter top level
module pamShapingFilterSva (
	input logic sys_clk,
	input logic reset,
	input logic sampleEn,
	input pamFilterPkg::sample_t y
);

	// a cycle without an enable freezes the whole pipeline
	property holdWithoutEnable;
		@(posedge sys_clk) disable iff (reset)
			!sampleEn |=> $stable(y);
	endproperty

	// every register clears on reset
	property zeroAfterReset;
		@(posedge sys_clk) reset |=> (y == '0);
	endproperty

	yHoldCheck: assert property (holdWithoutEnable)
		else $error("y changed in a cycle without sampleEn");

	yResetCheck: assert property (zeroAfterReset)
		else $error("y not zero in the cycle after reset");

endmodule

bind pamShapingFilter pamShapingFilterSva outputChecks (
	.sys_clk (sys_clk),
	.reset (reset),
	.sampleEn (sampleEn),
	.y (y)
);

// File: bench/tbPamShapingFilter.sv
`timescale 1ns/10ps

module tbPamShapingFilter;

	localparam int CLOCK_HALF = 20;
	localparam int RESET_CYCLES = 10;
	// taps to pre-sum, products, three tree levels
	localparam int PIPE_LATENCY = 5;
	localparam int FLUSH_ENABLES = 20;
	localparam int STREAM_LENGTH = 200;
	// roughly 570 enables, most of them two cycles apart, gap test up to seven
	localparam int CYCLE_LIMIT = 6000;

	logic sys_clk = 1'b0;
	logic reset = 1'b1;
	logic sampleEn = 1'b0;
	pamFilterPkg::sample_t x_in = '0;
	pamFilterPkg::sample_t y;

	// model state, halved samples with index 0 the newest
	int history [pamFilterPkg::TAP_COUNT];
	pamFilterPkg::sample_t expectedQueue [$];
	pamFilterPkg::sample_t stream [$];
	pamFilterPkg::sample_t recordedY [$];
	pamFilterPkg::sample_t lastY;
	int errorCount = 0;
	int cycleCount = 0;

	pamShapingFilter u_dut (
		.sys_clk (sys_clk),
		.reset (reset),
		.sampleEn (sampleEn),
		.x_in (x_in),
		.y (y)
	);

	initial begin
		forever #CLOCK_HALF sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("TEST FAIL");
			$display("run timed out after %0d clock cycles", cycleCount);
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input string name, input pamFilterPkg::sample_t expected,
			input pamFilterPkg::sample_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: %s expected %0d, actual %0d", $time, name,
				expected, actual);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// nearest level multiple of value, zero when outside the window
	// pairs take even multiples up to 6, the center odd ones up to 3
	function automatic int matchedMultiple(input int value, input bit pairTap);
		int m;
		int remainder;
		bit legal;
		if (value >= 0)
			m = (value + pamFilterPkg::LEVEL_STEP / 2) / pamFilterPkg::LEVEL_STEP;
		else
			m = -((pamFilterPkg::LEVEL_STEP / 2 - value) / pamFilterPkg::LEVEL_STEP);
		remainder = value - m * pamFilterPkg::LEVEL_STEP;
		if (pairTap)
			legal = (m % 2 == 0) && (m >= -6) && (m <= 6);
		else
			legal = (m % 2 != 0) && (m >= -3) && (m <= 3);
		if (remainder <= -pamFilterPkg::TOLERANCE || remainder >= pamFilterPkg::TOLERANCE)
			legal = 1'b0;
		return legal ? m : 0;
	endfunction

	// shift one sample into the model and queue the filter output it leads to
	function automatic void modelStep(input pamFilterPkg::sample_t s);
		int total;
		int pairValue;
		for (int i = pamFilterPkg::TAP_COUNT - 1; i > 0; i--) begin
			history[i] = history[i-1];
		end
		history[0] = int'(s) >>> 1;
		total = 0;
		for (int k = 0; k < pamFilterPkg::PAIR_COUNT; k++) begin
			pairValue = history[k] + history[pamFilterPkg::TAP_COUNT-1-k];
			total += int'(pamFilterPkg::UNIT_COEF[k]) * matchedMultiple(pairValue, 1'b1);
		end
		total += int'(pamFilterPkg::UNIT_COEF[pamFilterPkg::CENTER_TAP])
			* matchedMultiple(history[pamFilterPkg::CENTER_TAP], 1'b0);
		expectedQueue.push_back(pamFilterPkg::sample_t'(total));
	endfunction

	function automatic pamFilterPkg::sample_t randomSymbol();
		case ($urandom_range(3))
			0: return pamFilterPkg::sample_t'(-98304);
			1: return pamFilterPkg::sample_t'(-32768);
			2: return pamFilterPkg::sample_t'(32768);
			default: return pamFilterPkg::sample_t'(98304);
		endcase
	endfunction

	// idle cycles first, then one enable, then check y against the model
	task automatic applySample(input pamFilterPkg::sample_t s, input int gap);
		repeat (gap) begin
			@(posedge sys_clk);
			sampleEn <= 1'b0;
			@(negedge sys_clk);
			checkValue("y idle", lastY, y);
		end
		@(posedge sys_clk);
		sampleEn <= 1'b1;
		x_in <= s;
		@(posedge sys_clk);
		sampleEn <= 1'b0;
		modelStep(s);
		@(negedge sys_clk);
		checkValue("y", expectedQueue.pop_front(), y);
		lastY = y;
	endtask

	// enough zeros to clear all taps and every stage behind them
	task automatic flushPipeline();
		repeat (FLUSH_ENABLES) applySample('0, 0);
		checkValue("y flushed", '0, y);
	endtask

	task automatic zeroInputTest();
		for (int i = 0; i < 10; i++) begin
			applySample('0, 0);
			checkValue("y zero input", '0, y);
		end
	endtask

	// a lone half-step pair sum is odd and matches no pair level
	// only the center tap passes, with level +1
	task automatic impulseTest();
		int tapIndex;
		pamFilterPkg::sample_t expected;
		applySample(pamFilterPkg::sample_t'(32768), 0);
		for (int j = 1; j < PIPE_LATENCY + pamFilterPkg::TAP_COUNT; j++) begin
			applySample('0, 0);
			tapIndex = j - PIPE_LATENCY;
			if (tapIndex == pamFilterPkg::CENTER_TAP)
				expected = pamFilterPkg::UNIT_COEF[pamFilterPkg::CENTER_TAP];
			else
				expected = '0;
			checkValue("y impulse", expected, y);
		end
	endtask

	task automatic randomStreamTest();
		pamFilterPkg::sample_t s;
		flushPipeline();
		for (int i = 0; i < STREAM_LENGTH; i++) begin
			s = randomSymbol();
			stream.push_back(s);
			applySample(s, 0);
			recordedY.push_back(y);
		end
	endtask

	// same samples as the random stream, now with idle gaps
	task automatic gapReplayTest();
		flushPipeline();
		for (int i = 0; i < STREAM_LENGTH; i++) begin
			applySample(stream[i], int'($urandom_range(5)));
			checkValue("y gap replay", recordedY[i], y);
		end
	endtask

	task automatic toleranceTest();
		int offset;
		flushPipeline();
		for (int i = 0; i < 60; i++) begin
			offset = int'($urandom_range(8)) - 4;
			applySample(pamFilterPkg::sample_t'(int'(randomSymbol()) + offset), 0);
		end
		// every tap far off its level once the line is full
		for (int i = 0; i < FLUSH_ENABLES; i++) begin
			applySample(pamFilterPkg::sample_t'(int'(randomSymbol()) + 200), 0);
		end
		checkValue("y far offset", '0, y);
	endtask

	initial begin
		void'($urandom(32'hd08d5639));
		for (int i = 0; i < pamFilterPkg::TAP_COUNT; i++) begin
			history[i] = 0;
		end
		repeat (PIPE_LATENCY) expectedQueue.push_back('0);
		repeat (RESET_CYCLES) @(posedge sys_clk);
		reset <= 1'b0;
		@(negedge sys_clk);
		checkValue("y after reset", '0, y);
		lastY = y;

		zeroInputTest();
		impulseTest();
		randomStreamTest();
		gapReplayTest();
		toleranceTest();

		if (errorCount == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: filelist.f
verilog/pamFilterPkg.sv
verilog/foldedDelayLine.sv
verilog/levelLutMultiplier.sv
verilog/productAdderTree.sv
verilog/pamShapingFilter.sv
bench/pamShapingFilter_sva.sv
bench/tbPamShapingFilter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PAM shaping filter testbench with Verilator.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tbPamShapingFilter \
	-o simPamShapingFilter
./obj_dir/simPamShapingFilter
